//--- src/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// --------------------
// widths and reset
// --------------------
`define RV_XLEN      32
`define RV_NREGS     32
`define RV_RESET_PC  32'h0000_0000   // first fetch address

// --------------------
// major opcodes, instr[6:0]
// --------------------
`define RV_OP_LOAD   7'b0000011  // lw
`define RV_OP_STORE  7'b0100011  // sw
`define RV_OP_IMM    7'b0010011  // addi, ori
`define RV_OP_REG    7'b0110011  // r-type
`define RV_OP_LUI    7'b0110111
`define RV_OP_JAL    7'b1101111
`define RV_OP_JALR   7'b1100111
`define RV_OP_BRANCH 7'b1100011

// --------------------
// alu codes, 0101 (xor) unused
// --------------------
`define RV_ALU_ADD   4'b0000
`define RV_ALU_SUB   4'b0001
`define RV_ALU_SLL   4'b0010
`define RV_ALU_SLT   4'b0011
`define RV_ALU_SLTU  4'b0100
`define RV_ALU_SRL   4'b0110
`define RV_ALU_SRA   4'b0111
`define RV_ALU_OR    4'b1000
`define RV_ALU_AND   4'b1001

// --------------------
// funct3 / funct7
// --------------------
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001
`define RV_F3_BLT    3'b100
`define RV_F3_BGE    3'b101
`define RV_F3_BLTU   3'b110
`define RV_F3_BGEU   3'b111
`define RV_F3_ADD    3'b000  // add, sub, addi
`define RV_F3_SLL    3'b001
`define RV_F3_SLT    3'b010
`define RV_F3_SLTU   3'b011
`define RV_F3_SR     3'b101  // srl and sra, split by funct7
`define RV_F3_OR     3'b110  // or, ori
`define RV_F3_AND    3'b111
`define RV_F7_BASE   7'b0000000
`define RV_F7_ALT    7'b0100000  // sub, sra

`endif

//--- src/rv_pkg.sv
`include "rv_defines.svh"

package rv_pkg;

    // --------------------
    // vector types
    // --------------------
    typedef logic [`RV_XLEN-1:0] word_t;      // data / address
    typedef logic [4:0]          reg_addr_t;  // x0..x31
    typedef logic [31:0]         instr_t;     // raw instruction word
    typedef logic [3:0]          alu_op_t;    // RV_ALU_* codes
    typedef logic [2:0]          funct3_t;

    // --------------------
    // stage machine
    // --------------------
    typedef enum logic [1:0] {
        IF_STAGE,   // fetch, waits on mem_ready
        EX_STAGE,   // one cycle
        MEM_STAGE,  // lw / sw only
        WB_STAGE    // reg write + pc update
    } stage_t;

    // decoded control, one instruction's worth
    typedef struct packed {
        logic    mem_write;   // sw
        logic    reg_write;   // rd gets wb data
        logic    mem_to_reg;  // lw, wb from load data
        logic    in1_is_reg;  // alu in1 = rs1, else zero
        logic    in2_is_reg;  // alu in2 = rs2, else imm
        logic    branch;      // conditional branch
        logic    jump;        // jal or jalr
        logic    jump_reg;    // jalr only
        alu_op_t alu_op;
    } ctrl_t;

endpackage

//--- src/rv_decoder.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_decoder (
    input  rv_pkg::instr_t instr,
    output rv_pkg::ctrl_t  ctrl
);
    import rv_pkg::*;

    logic [6:0] opcode;
    funct3_t    funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        // defaults: add, nothing written
        ctrl        = '0;
        ctrl.alu_op = `RV_ALU_ADD;

        case (opcode)
            `RV_OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.in1_is_reg = 1'b1;  // addr = rs1 + imm
            end
            `RV_OP_STORE: begin
                ctrl.mem_write  = 1'b1;
                ctrl.in1_is_reg = 1'b1;
            end
            `RV_OP_IMM: begin
                ctrl.in1_is_reg = 1'b1;
                // alu op straight from funct3
                case (funct3)
                    `RV_F3_ADD: ctrl.reg_write = 1'b1;  // addi
                    `RV_F3_OR: begin                    // ori
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = `RV_ALU_OR;
                    end
                    default: ctrl.reg_write = 1'b0;     // not in subset
                endcase
            end
            `RV_OP_REG: begin
                ctrl.in1_is_reg = 1'b1;
                ctrl.in2_is_reg = 1'b1;
                ctrl.reg_write  = 1'b1;
                // funct7 + funct3 together
                case ({funct7, funct3})
                    {`RV_F7_BASE, `RV_F3_ADD}:  ctrl.alu_op = `RV_ALU_ADD;
                    {`RV_F7_ALT,  `RV_F3_ADD}:  ctrl.alu_op = `RV_ALU_SUB;
                    {`RV_F7_BASE, `RV_F3_SLL}:  ctrl.alu_op = `RV_ALU_SLL;
                    {`RV_F7_BASE, `RV_F3_SLT}:  ctrl.alu_op = `RV_ALU_SLT;
                    {`RV_F7_BASE, `RV_F3_SLTU}: ctrl.alu_op = `RV_ALU_SLTU;
                    {`RV_F7_BASE, `RV_F3_SR}:   ctrl.alu_op = `RV_ALU_SRL;
                    {`RV_F7_ALT,  `RV_F3_SR}:   ctrl.alu_op = `RV_ALU_SRA;
                    {`RV_F7_BASE, `RV_F3_OR}:   ctrl.alu_op = `RV_ALU_OR;
                    {`RV_F7_BASE, `RV_F3_AND}:  ctrl.alu_op = `RV_ALU_AND;
                    default: begin
                        ctrl.reg_write = 1'b0;  // unknown r-type, drop it
                        ctrl.alu_op    = `RV_ALU_ADD;
                    end
                endcase
            end
            `RV_OP_LUI: begin
                ctrl.reg_write = 1'b1;  // 0 + (imm << 12)
            end
            `RV_OP_JAL: begin
                ctrl.reg_write = 1'b1;  // rd = pc + 4
                ctrl.jump      = 1'b1;
            end
            `RV_OP_JALR: begin
                ctrl.reg_write  = 1'b1;
                ctrl.in1_is_reg = 1'b1;  // target = rs1 + imm
                ctrl.jump       = 1'b1;
                ctrl.jump_reg   = 1'b1;
            end
            `RV_OP_BRANCH: begin
                ctrl.in1_is_reg = 1'b1;
                ctrl.in2_is_reg = 1'b1;
                ctrl.branch     = 1'b1;
                ctrl.alu_op     = `RV_ALU_SUB;
            end
            default: begin
                ctrl        = '0;  // unknown opcode, behaves as a nop
                ctrl.alu_op = `RV_ALU_ADD;
            end
        endcase
    end

endmodule

//--- src/rv_immgen.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_immgen (
    input  rv_pkg::instr_t instr,
    output rv_pkg::word_t  imm
);

    logic [6:0]  opcode;
    logic [11:0] imm_i;  // also jalr, loads
    logic [11:0] imm_s;
    logic [12:0] imm_b;  // bit 0 always zero
    logic [19:0] imm_u;
    logic [20:0] imm_j;  // bit 0 always zero

    assign opcode = instr[6:0];

    // --------------------
    // field assembly
    // --------------------
    assign imm_i = instr[31:20];
    assign imm_s = {instr[31:25], instr[11:7]};
    assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = instr[31:12];
    assign imm_j = {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode)
            `RV_OP_STORE:  imm = {{20{imm_s[11]}}, imm_s};
            `RV_OP_BRANCH: imm = {{19{imm_b[12]}}, imm_b};
            `RV_OP_JAL:    imm = {{11{imm_j[20]}}, imm_j};
            `RV_OP_LUI:    imm = {imm_u, 12'h000};     // upper bits, no extend
            default:       imm = {{20{imm_i[11]}}, imm_i};  // i-type
        endcase
    end

endmodule

//--- src/rv_alu.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu (
    input  rv_pkg::word_t   in1,
    input  rv_pkg::word_t   in2,
    input  rv_pkg::alu_op_t op,
    output rv_pkg::word_t   result
);

    logic [4:0]  shamt;      // low five bits only
    logic        lt_signed;
    logic        lt_unsigned;

    assign shamt       = in2[4:0];
    assign lt_signed   = $signed(in1) < $signed(in2);
    assign lt_unsigned = in1 < in2;

    always_comb begin
        case (op)
            `RV_ALU_ADD:  result = in1 + in2;
            `RV_ALU_SUB:  result = in1 - in2;
            `RV_ALU_SLL:  result = in1 << shamt;
            `RV_ALU_SLT:  result = {31'b0, lt_signed};
            `RV_ALU_SLTU: result = {31'b0, lt_unsigned};
            `RV_ALU_SRL:  result = in1 >> shamt;
            `RV_ALU_SRA:  result = $signed(in1) >>> shamt;  // keeps sign bit
            `RV_ALU_OR:   result = in1 | in2;
            `RV_ALU_AND:  result = in1 & in2;
            default:      result = '0;  // decoder never emits these
        endcase
    end

endmodule

//--- src/rv_branch_cmp.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_branch_cmp (
    input  rv_pkg::word_t   rs1_data,
    input  rv_pkg::word_t   rs2_data,
    input  rv_pkg::funct3_t funct3,
    output logic            taken
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = rs1_data == rs2_data;
    assign lt_s = $signed(rs1_data) < $signed(rs2_data);
    assign lt_u = rs1_data < rs2_data;

    always_comb begin
        case (funct3)
            `RV_F3_BEQ:  taken = eq;
            `RV_F3_BNE:  taken = !eq;
            `RV_F3_BLT:  taken = lt_s;
            `RV_F3_BGE:  taken = !lt_s;
            `RV_F3_BLTU: taken = lt_u;
            `RV_F3_BGEU: taken = !lt_u;
            default:     taken = 1'b0;  // 010 / 011 reserved
        endcase
    end

endmodule

//--- src/rv_regfile.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              we,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     rd_data,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);
    import rv_pkg::*;

    word_t regs [`RV_NREGS];  // x0 slot is written but never read

    // combinational read, x0 forced to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[rd_addr] <= rd_data;  // end of WB_STAGE
        end
    end

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
    input  logic          clk,
    input  logic          reset_n,
    // native memory bus
    output logic          mem_valid,
    output logic          mem_instr,
    input  logic          mem_ready,
    output rv_pkg::word_t mem_addr,
    output rv_pkg::word_t mem_wdata,
    output logic [3:0]    mem_wstrb,
    input  rv_pkg::word_t mem_rdata
);
    import rv_pkg::*;

    stage_t    stage, stage_next;
    word_t     pc, pc_next;
    instr_t    instr_reg;    // latched at end of fetch
    word_t     load_data;    // lw data, latched at end of MEM_STAGE

    ctrl_t     ctrl;
    word_t     imm;
    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    word_t     rs1_data, rs2_data;
    word_t     alu_in1, alu_in2, alu_result;
    logic      br_taken;
    word_t     pc_plus4, pc_plus_imm;
    word_t     wb_data;
    logic      rf_we;
    logic      store_active;

    // --------------------
    // memory bus drive
    // --------------------
    assign mem_valid    = (stage == IF_STAGE) || (stage == MEM_STAGE);
    assign mem_instr    = stage == IF_STAGE;
    assign store_active = (stage == MEM_STAGE) && ctrl.mem_write;

    assign mem_addr  = (stage == IF_STAGE)  ? pc :
                       (stage == MEM_STAGE) ? alu_result  // rs1 + imm
                                            : '0;
    assign mem_wdata = store_active ? rs2_data : '0;
    assign mem_wstrb = {4{store_active}};  // full words only

    // --------------------
    // decode
    // --------------------
    assign rs1_addr = instr_reg[19:15];
    assign rs2_addr = instr_reg[24:20];
    assign rd_addr  = instr_reg[11:7];

    rv_decoder decoder_i (
        .instr (instr_reg),
        .ctrl  (ctrl)
    );

    rv_immgen immgen_i (
        .instr (instr_reg),
        .imm   (imm)
    );

    rv_regfile regfile_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .we       (rf_we),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rd_addr  (rd_addr),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // --------------------
    // execute
    // --------------------
    assign alu_in1 = ctrl.in1_is_reg ? rs1_data : '0;   // zero for lui
    assign alu_in2 = ctrl.in2_is_reg ? rs2_data : imm;

    rv_alu alu_i (
        .in1    (alu_in1),
        .in2    (alu_in2),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    // compares raw register operands, alongside the alu
    rv_branch_cmp branch_cmp_i (
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .funct3   (instr_reg[14:12]),
        .taken    (br_taken)
    );

    // --------------------
    // writeback and next pc
    // --------------------
    assign pc_plus4    = pc + 32'd4;
    assign pc_plus_imm = pc + imm;

    assign wb_data = ctrl.mem_to_reg ? load_data :
                     ctrl.jump       ? pc_plus4     // link address
                                     : alu_result;
    assign rf_we   = (stage == WB_STAGE) && ctrl.reg_write;

    always_comb begin
        if (ctrl.jump_reg) begin
            pc_next = {alu_result[31:1], 1'b0};  // jalr clears bit 0
        end else if ((ctrl.branch && br_taken) || ctrl.jump) begin
            pc_next = pc_plus_imm;               // taken branch or jal
        end else begin
            pc_next = pc_plus4;
        end
    end

    // stage sequencing
    always_comb begin
        stage_next = stage;
        case (stage)
            IF_STAGE:  if (mem_ready) stage_next = EX_STAGE;
            EX_STAGE: begin
                if (ctrl.mem_write || ctrl.mem_to_reg) begin
                    stage_next = MEM_STAGE;  // lw / sw
                end else begin
                    stage_next = WB_STAGE;   // skip memory
                end
            end
            MEM_STAGE: if (mem_ready) stage_next = WB_STAGE;
            WB_STAGE:  stage_next = IF_STAGE;
            default:   stage_next = IF_STAGE;
        endcase
    end

    // control state
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stage <= IF_STAGE;
            pc    <= `RV_RESET_PC;
        end else begin
            stage <= stage_next;
            if (stage == WB_STAGE) begin
                pc <= pc_next;  // only place the pc moves
            end
        end
    end

    // payload, captured on the ready cycle
    always_ff @(posedge clk) begin
        if ((stage == IF_STAGE) && mem_ready) begin
            instr_reg <= mem_rdata;
        end
        if ((stage == MEM_STAGE) && mem_ready) begin
            load_data <= mem_rdata;  // harmless on sw
        end
    end

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // low for 4 rising edges, released just after the last one
    initial begin
        reset_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;
    end

endmodule

//--- tb/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_rv_core;
    import rv_pkg::*;

    // --------------------
    // program and bus types
    // --------------------
    typedef enum logic [3:0] {
        K_LW, K_SW, K_ADDI, K_ORI, K_REG, K_LUI, K_JAL, K_JALR, K_BR
    } kind_t;

    typedef struct packed {
        kind_t      kind;
        logic [3:0] sub;   // {funct7 alt bit, funct3}
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;   // lui value already shifted up
    } op_t;

    typedef struct packed {
        logic       valid;
        logic       instr;
        word_t      addr;
        word_t      wdata;
        logic [3:0] wstrb;
    } bus_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam int    BODY    = 31;       // random words before the 32 dump stores
    localparam word_t LOOP_PC = 32'd252;  // word 63
    localparam int    TIMEOUT = 2000;

    logic       clk, reset_n;
    logic       mem_valid, mem_instr, mem_ready;
    word_t      mem_addr, mem_wdata, mem_rdata;
    logic [3:0] mem_wstrb;
    bus_t       bus_now, held;            // held = request as first seen

    op_t    prog [64];
    word_t  mem [256];                    // 0x000 code, 0x200 data, 0x300 register dump
    word_t  model_mem [256];
    word_t  model_regs [32];
    word_t  exp_fetch [$];                // pc sequence of the model
    store_t exp_store [$];

    int fetch_idx, store_idx, value_errors, other_errors, delay;
    bit pending;

    tb_clock clock_i (.clk(clk), .reset_n(reset_n));

    rv_core dut_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .mem_valid (mem_valid),
        .mem_instr (mem_instr),
        .mem_ready (mem_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wstrb (mem_wstrb),
        .mem_rdata (mem_rdata)
    );

    assign bus_now = {mem_valid, mem_instr, mem_addr, mem_wdata, mem_wstrb};

    // --------------------
    // helpers
    // --------------------
    function automatic void report_mismatch(string name, word_t got, word_t exp);
        $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        value_errors++;
    endfunction

    // rv32i r-type results
    function automatic word_t r_result(logic [3:0] sub, word_t a, word_t b);
        case (sub)
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return {31'b0, $signed(a) < $signed(b)};
            4'b0011: return {31'b0, a < b};
            4'b0101: return a >> b[4:0];
            4'b1101: return $signed(a) >>> b[4:0];
            4'b0110: return a | b;
            4'b0111: return a & b;
            default: return a + b;
        endcase
    endfunction

    function automatic bit branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // standard rv32i field layouts
    function automatic instr_t encode(op_t o);
        logic [11:0] i12;
        i12 = o.imm[11:0];
        case (o.kind)
            K_SW:   return {i12[11:5], o.rs2, o.rs1, o.sub[2:0], i12[4:0], `RV_OP_STORE};
            K_REG:  return {1'b0, o.sub[3], 5'b0, o.rs2, o.rs1, o.sub[2:0], o.rd, `RV_OP_REG};
            K_LUI:  return {o.imm[31:12], o.rd, `RV_OP_LUI};
            K_JAL:  return {o.imm[20], o.imm[10:1], o.imm[11], o.imm[19:12], o.rd, `RV_OP_JAL};
            K_BR:   return {o.imm[12], o.imm[10:5], o.rs2, o.rs1, o.sub[2:0], o.imm[4:1],
                            o.imm[11], `RV_OP_BRANCH};
            K_LW:   return {i12, o.rs1, o.sub[2:0], o.rd, `RV_OP_LOAD};
            K_JALR: return {i12, o.rs1, o.sub[2:0], o.rd, `RV_OP_JALR};
            default: return {i12, o.rs1, o.sub[2:0], o.rd, `RV_OP_IMM};  // addi, ori
        endcase
    endfunction

    // --------------------
    // random program
    // --------------------
    task automatic build_program();
        op_t o;
        int  t;
        int  f;
        int  g;
        for (int i = 0; i < BODY; i++) begin
            o      = '0;
            o.kind = kind_t'($urandom_range(0, 8));
            o.rd   = $urandom_range(0, 31);
            o.rs1  = $urandom_range(0, 31);
            o.rs2  = $urandom_range(0, 31);
            o.imm  = $urandom;
            t      = $urandom_range(i + 1, BODY);  // forward only up to the dump block
            f      = $urandom_range(0, 6);
            g      = $urandom_range(0, 5);
            case (o.kind)
                K_LW, K_SW: begin
                    o.sub = 4'b0010;
                    o.rs1 = '0;                          // x0 base
                    o.imm = 32'h200 + 4 * o.imm[5:0];    // data region
                end
                K_ADDI, K_ORI: begin
                    o.sub = (o.kind == K_ORI) ? 4'b0110 : 4'b0000;
                    o.imm = {{20{o.imm[11]}}, o.imm[11:0]};
                end
                K_REG: begin
                    o.sub[2:0] = (f < 4) ? f : f + 1;  // skips xor
                    o.sub[3]   = o.imm[0] && (o.sub[2:0] == 3'b000 || o.sub[2:0] == 3'b101);
                end
                K_LUI: o.imm[11:0] = '0;
                K_JAL: o.imm = (t - i) * 4;
                K_JALR: begin
                    o.rs1 = '0;
                    o.imm = t * 4;  // absolute target
                end
                default: begin
                    o.sub = (g < 2) ? g : g + 2;  // beq bne blt bge bltu bgeu
                    o.imm = (t - i) * 4;
                end
            endcase
            prog[i] = o;
        end
        // dump block stores xr to 0x300 + 4r
        for (int r = 0; r < 32; r++) begin
            o              = '0;
            o.kind         = K_SW;
            o.sub          = 4'b0010;
            o.rs2          = r;
            o.imm          = 32'h300 + 4 * r;
            prog[BODY + r] = o;
        end
        o        = '0;
        o.kind   = K_JAL;  // jal x0, 0
        prog[63] = o;
        for (int a = 0; a < 256; a++) begin
            mem[a]       = (a < 64) ? encode(prog[a]) : $urandom;
            model_mem[a] = mem[a];
        end
    endtask

    // --------------------
    // instruction-set model
    // --------------------
    task automatic run_model();
        word_t pc, next_pc, a, b, ea, wb;
        bit    do_wb;
        op_t   o;
        pc = `RV_RESET_PC;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        for (int step = 0; step < 1000; step++) begin
            exp_fetch.push_back(pc);
            o       = prog[pc[7:2]];
            a       = (o.rs1 == 0) ? '0 : model_regs[o.rs1];
            b       = (o.rs2 == 0) ? '0 : model_regs[o.rs2];
            ea      = a + o.imm;
            next_pc = pc + 4;
            do_wb   = 1'b1;
            wb      = '0;
            case (o.kind)
                K_LW: wb = model_mem[ea[9:2]];
                K_SW: begin
                    do_wb                = 1'b0;
                    model_mem[ea[9:2]]   = b;
                    exp_store.push_back({ea, b});
                end
                K_ADDI, K_ORI: wb = (o.kind == K_ORI) ? (a | o.imm) : ea;
                K_REG: wb = r_result(o.sub, a, b);
                K_LUI: wb = o.imm;
                K_JAL: begin
                    wb      = pc + 4;
                    next_pc = pc + o.imm;
                end
                K_JALR: begin
                    wb      = pc + 4;
                    next_pc = ea & ~32'd1;
                end
                default: begin
                    do_wb = 1'b0;
                    if (branch_taken(o.sub[2:0], a, b)) next_pc = pc + o.imm;
                end
            endcase
            if (do_wb && o.rd != 0) model_regs[o.rd] = wb;
            if (next_pc == pc) break;  // final self-loop
            pc = next_pc;
        end
    endtask

    // --------------------
    // memory model and bus checks
    // --------------------
    function automatic void check_hold();
        assert (bus_now.valid == held.valid)
            else report_mismatch("mem_valid", bus_now.valid, held.valid);
        assert (bus_now.addr == held.addr)
            else report_mismatch("mem_addr", bus_now.addr, held.addr);
        assert (bus_now.wdata == held.wdata)
            else report_mismatch("mem_wdata", bus_now.wdata, held.wdata);
        assert (bus_now.wstrb == held.wstrb)
            else report_mismatch("mem_wstrb", bus_now.wstrb, held.wstrb);
    endfunction

    task automatic finish_transfer();
        word_t  exp_pc;
        store_t st;
        if (held.instr) begin
            exp_pc = (fetch_idx < exp_fetch.size()) ? exp_fetch[fetch_idx] : LOOP_PC;
            assert (held.addr == exp_pc) else report_mismatch("fetch mem_addr", held.addr, exp_pc);
            fetch_idx++;
        end else if (held.wstrb != 4'h0) begin
            mem[held.addr[9:2]] = held.wdata;
            assert (held.wstrb == 4'hf) else report_mismatch("mem_wstrb", held.wstrb, 32'hf);
            assert (store_idx < exp_store.size()) else begin
                $display("[ERROR] t=%0t store to %h that the model never makes", $time, held.addr);
                other_errors++;
            end
            if (store_idx < exp_store.size()) begin
                st = exp_store[store_idx];
                assert (held.addr == st.addr)
                    else report_mismatch("store mem_addr", held.addr, st.addr);
                assert (held.wdata == st.data)
                    else report_mismatch("store mem_wdata", held.wdata, st.data);
            end
            store_idx++;
        end
    endtask

    // samples at the edge and drives 1 ns after it
    always @(posedge clk) begin
        if (!reset_n) begin
            pending = 1'b0;
        end else if (mem_ready) begin
            check_hold();
            finish_transfer();
            pending = 1'b0;
            #1;
            mem_ready = 1'b0;  // one-cycle ready
            mem_rdata = '0;
        end else if (mem_valid || pending) begin
            if (pending) begin
                check_hold();  // also catches a dropped mem_valid
            end else begin
                pending = 1'b1;
                held    = bus_now;
                delay   = $urandom_range(0, 3);
            end
            if (delay == 0) begin
                #1;
                mem_ready = 1'b1;
                mem_rdata = mem[held.addr[9:2]];
            end else begin
                delay--;
            end
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        int unsigned seed_ret;
        int          cnt;
        bit          timed_out;
        word_t       exp_reg;
        seed_ret  = $urandom(32'hc3f40185);
        mem_ready = 1'b0;
        mem_rdata = '0;
        build_program();
        run_model();

        cnt = 0;
        while (!reset_n && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        assert (reset_n) else begin
            $display("reset_n was never released");
            other_errors++;
        end
        // state right after reset
        assert (mem_valid == 1'b1) else report_mismatch("mem_valid", mem_valid, 32'd1);
        assert (mem_instr == 1'b1) else report_mismatch("mem_instr", mem_instr, 32'd1);
        assert (mem_addr == `RV_RESET_PC)
            else report_mismatch("mem_addr", mem_addr, `RV_RESET_PC);
        assert (mem_wstrb == 4'h0) else report_mismatch("mem_wstrb", mem_wstrb, 32'd0);

        // every model fetch plus two turns of the final loop
        timed_out = 1'b0;
        for (int t = 1; t <= exp_fetch.size() + 2 && !timed_out; t++) begin
            cnt = 0;
            while (fetch_idx < t && cnt < TIMEOUT) begin
                @(negedge clk);
                cnt++;
            end
            if (fetch_idx < t) begin
                $display("timeout, fetch %0d not seen within %0d cycles", t, TIMEOUT);
                other_errors++;
                timed_out = 1'b1;
            end
        end

        assert (store_idx == exp_store.size()) else begin
            $display("[ERROR] t=%0t saw %0d stores, model made %0d", $time, store_idx,
                     exp_store.size());
            other_errors++;
        end
        // dump area against model registers with x0 as zero
        for (int r = 0; r < 32; r++) begin
            exp_reg = (r == 0) ? '0 : model_regs[r];
            assert (mem[192 + r] == exp_reg)
                else report_mismatch($sformatf("dump of x%0d", r), mem[192 + r], exp_reg);
        end

        $display("errors: %0d value, %0d other (%0d fetches, %0d stores seen)",
                 value_errors, other_errors, fetch_idx, store_idx);
        if (value_errors + other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/rv_pkg.sv
src/rv_decoder.sv
src/rv_immgen.sv
src/rv_alu.sv
src/rv_branch_cmp.sv
src/rv_regfile.sv
src/rv_core.sv
tb/tb_clock.sv
tb/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/rv_decoder.sv
      - src/rv_immgen.sv
      - src/rv_alu.sv
      - src/rv_branch_cmp.sv
      - src/rv_regfile.sv
      - src/rv_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/tb_clock.sv
      - tb/tb_rv_core.sv
